// ==== Makefile ====
TOOL      = verilator
SIM_FLAGS = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP       = soc_bus_tb
RTL_TOP   = soc_bus_top
FILELIST  = vlog.f
LOG       = sim.log
PASS      = Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== src/bus_fabric.sv ====
`default_nettype none

module bus_fabric (
	input  logic              clk,
	input  logic              reset_i,
	input  soc_pkg::bus_req_t m_req_i,
	output soc_pkg::bus_rsp_t m_rsp_o,
	output soc_pkg::bus_req_t ram_req_o,
	output soc_pkg::bus_req_t io_req_o,
	output soc_pkg::bus_req_t tmr_req_o,
	input  soc_pkg::bus_rsp_t ram_rsp_i,
	input  soc_pkg::bus_rsp_t io_rsp_i,
	input  soc_pkg::bus_rsp_t tmr_rsp_i
);
	import soc_pkg::*;

	logic ram_hit;
	logic io_hit;
	logic tmr_hit;
	logic unmapped;
	logic err_q;
	logic err_hold_q;

	assign ram_hit = (m_req_i.adr[31:16] == RAM_BASE_HI);
	assign io_hit  = (m_req_i.adr[31:16] == TEXT_BASE_HI);
	assign tmr_hit = (m_req_i.adr[31:8] == TIMER_BASE);

	assign unmapped = m_req_i.cyc & m_req_i.stb & ~(ram_hit | io_hit | tmr_hit);

	// stb reaches only the decoded target
	always_comb begin
		ram_req_o = m_req_i;
		io_req_o  = m_req_i;
		tmr_req_o = m_req_i;
		ram_req_o.stb = m_req_i.stb & ram_hit;
		io_req_o.stb  = m_req_i.stb & io_hit;
		tmr_req_o.stb = m_req_i.stb & tmr_hit;
	end

	// one err per unmapped strobe, rearmed when stb drops
	always_ff @(posedge clk) begin
		if (reset_i) begin
			err_q      <= 1'b0;
			err_hold_q <= 1'b0;
		end else begin
			err_q      <= unmapped & ~err_hold_q;
			err_hold_q <= unmapped;
		end
	end

	// idle targets return zero data, so a plain OR merges them
	always_comb begin
		m_rsp_o.ack = ram_rsp_i.ack | io_rsp_i.ack | tmr_rsp_i.ack;
		m_rsp_o.err = err_q | ram_rsp_i.err | io_rsp_i.err | tmr_rsp_i.err;
		m_rsp_o.dat = ram_rsp_i.dat | io_rsp_i.dat | tmr_rsp_i.dat;
	end

endmodule

`default_nettype wire

// ==== src/interval_timer.sv ====
`default_nettype none

module interval_timer (
	input  logic              clk,
	input  logic              reset_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o,
	output logic              irq_o
);
	import soc_pkg::*;

	io_data_t reload_q;
	io_data_t count_q;
	io_data_t rd_q;
	logic     enable_q;
	logic     pending_q;
	logic     ack_q;
	logic     access;
	logic     wr;

	assign access = req_i.cyc & req_i.stb & ~ack_q;
	assign wr     = access & req_i.we;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			reload_q  <= '0;
			count_q   <= '0;
			enable_q  <= 1'b0;
			pending_q <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			ack_q <= access;
			if (enable_q) begin
				if (count_q == '0) begin
					pending_q <= 1'b1;
					count_q   <= reload_q;
				end else
					count_q <= count_q - 1'b1;
			end
			// bus writes override the count step
			if (wr) begin
				case (req_i.adr[7:0])
					TMR_RELOAD: begin
						reload_q <= req_i.dat[31:0];
						count_q  <= req_i.dat[31:0]; // restart from new value
					end
					TMR_COUNT: count_q <= req_i.dat[31:0];
					TMR_CTRL: begin
						enable_q <= req_i.dat[0];
						if (req_i.dat[1])
							pending_q <= 1'b0; // write 1 to clear
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			case (req_i.adr[7:0])
				TMR_RELOAD: rd_q <= reload_q;
				TMR_COUNT:  rd_q <= count_q;
				TMR_CTRL:   rd_q <= {30'b0, pending_q, enable_q};
				default:    rd_q <= '0;
			endcase
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;
	assign rsp_o.dat = ack_q ? {32'b0, rd_q} : '0;
	assign irq_o     = pending_q;

endmodule

`default_nettype wire

// ==== src/io_bridge.sv ====
`default_nettype none

module io_bridge (
	input  logic              clk,
	input  logic              reset_i,
	input  soc_pkg::bus_req_t s_req_i,
	output soc_pkg::bus_rsp_t s_rsp_o,
	output soc_pkg::io_req_t  m_req_o,
	input  soc_pkg::io_rsp_t  m_rsp_i
);
	import soc_pkg::*;

	bridge_state_e state_q;
	bridge_state_e state_d;
	data_t         rdata_q;
	logic          start;
	logic          lo_want;
	logic          hi_want;
	logic          in_low;
	logic          in_high;

	assign start   = s_req_i.cyc & s_req_i.stb;
	assign lo_want = |s_req_i.sel[3:0];
	assign hi_want = |s_req_i.sel[7:4];
	assign in_low  = (state_q == low_beat);
	assign in_high = (state_q == high_beat);

	always_comb begin
		state_d = state_q;
		case (state_q)
			idle: begin
				if (start) begin
					if (lo_want)
						state_d = low_beat;
					else if (hi_want)
						state_d = high_beat;
					else
						state_d = done; // no lanes, nothing to move
				end
			end
			low_beat: begin
				if (m_rsp_i.ack)
					state_d = hi_want ? high_beat : done;
			end
			high_beat: begin
				if (m_rsp_i.ack)
					state_d = done;
			end
			done: state_d = idle;
			default: state_d = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			state_q <= idle;
		else
			state_q <= state_d;
	end

	// read word assembly, an unselected half stays zero
	always_ff @(posedge clk) begin
		if (state_q == idle && start)
			rdata_q <= '0;
		else if (in_low && m_rsp_i.ack)
			rdata_q[31:0] <= m_rsp_i.dat;
		else if (in_high && m_rsp_i.ack)
			rdata_q[63:32] <= m_rsp_i.dat;
	end

	// beats go back to back, so stb stays up across the low/high change
	always_comb begin
		m_req_o.cyc = in_low | in_high;
		m_req_o.stb = in_low | in_high;
		m_req_o.we  = s_req_i.we;
		m_req_o.sel = in_high ? s_req_i.sel[7:4] : s_req_i.sel[3:0];
		m_req_o.adr = {s_req_i.adr[31:3], in_high, 2'b00};
		m_req_o.dat = in_high ? s_req_i.dat[63:32] : s_req_i.dat[31:0];
	end

	assign s_rsp_o.ack = (state_q == done);
	assign s_rsp_o.err = 1'b0;
	assign s_rsp_o.dat = (state_q == done) ? rdata_q : '0;

endmodule

`default_nettype wire

// ==== src/scratch_ram.sv ====
`default_nettype none

module scratch_ram #(
	parameter int RAM_WORDS = 2048
) (
	input  logic              clk,
	input  logic              reset_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o
);
	import soc_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);

	data_t          mem [RAM_WORDS];
	data_t          rd_q;
	logic           ack_q;
	logic           access;
	logic [AW-1:0]  idx;

	assign idx    = req_i.adr[AW+2:3]; // 8-byte words
	assign access = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk) begin
		if (reset_i)
			ack_q <= 1'b0;
		else
			ack_q <= access; // held stb gets a single ack
	end

	always_ff @(posedge clk) begin
		if (access && req_i.we) begin
			for (int i = 0; i < 8; i++)
				if (req_i.sel[i])
					mem[idx][i*8 +: 8] <= req_i.dat[i*8 +: 8];
		end
		if (access)
			rd_q <= mem[idx]; // full word, lanes not masked
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;
	assign rsp_o.dat = ack_q ? rd_q : '0;

endmodule

`default_nettype wire

// ==== src/soc_bus_top.sv ====
`default_nettype none

module soc_bus_top #(
	parameter int RAM_WORDS  = 2048,
	parameter int TEXT_WORDS = 2048
) (
	input  logic              clk,
	input  logic              reset_i,
	input  soc_pkg::bus_req_t bus_req_i,
	output soc_pkg::bus_rsp_t bus_rsp_o,
	output logic              irq_o
);
	import soc_pkg::*;

	bus_req_t ram_req;
	bus_req_t io_req;
	bus_req_t tmr_req;
	bus_rsp_t ram_rsp;
	bus_rsp_t io_rsp;
	bus_rsp_t tmr_rsp;
	io_req_t  txt_req;
	io_rsp_t  txt_rsp;

	bus_fabric u_fabric (
		.clk       (clk),
		.reset_i   (reset_i),
		.m_req_i   (bus_req_i),
		.m_rsp_o   (bus_rsp_o),
		.ram_req_o (ram_req),
		.io_req_o  (io_req),
		.tmr_req_o (tmr_req),
		.ram_rsp_i (ram_rsp),
		.io_rsp_i  (io_rsp),
		.tmr_rsp_i (tmr_rsp)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (ram_req),
		.rsp_o   (ram_rsp)
	);

	io_bridge u_bridge (
		.clk     (clk),
		.reset_i (reset_i),
		.s_req_i (io_req),
		.s_rsp_o (io_rsp),
		.m_req_o (txt_req),
		.m_rsp_i (txt_rsp)
	);

	text_mem #(
		.TEXT_WORDS (TEXT_WORDS)
	) u_text (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (txt_req),
		.rsp_o   (txt_rsp)
	);

	interval_timer u_timer (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (tmr_req),
		.rsp_o   (tmr_rsp),
		.irq_o   (irq_o)
	);

endmodule

`default_nettype wire

// ==== src/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0]  sel_t;
	typedef logic [31:0] io_data_t;
	typedef logic [3:0]  io_sel_t;

	// request on the 64-bit bus
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		sel_t  sel;
		addr_t adr;
		data_t dat;
	} bus_req_t;

	typedef struct packed {
		logic  ack;
		logic  err;
		data_t dat;
	} bus_rsp_t;

	// 32-bit peripheral side of the bridge
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		io_sel_t  sel;
		addr_t    adr;
		io_data_t dat;
	} io_req_t;

	typedef struct packed {
		logic     ack;
		io_data_t dat;
	} io_rsp_t;

	typedef enum logic [1:0] {
		idle,
		low_beat,
		high_beat,
		done
	} bridge_state_e;

	localparam logic [15:0] RAM_BASE_HI  = 16'h0000;
	localparam logic [15:0] TEXT_BASE_HI = 16'hFFD0;
	localparam logic [23:0] TIMER_BASE   = 24'hFFDC07;

	localparam logic [7:0] TMR_RELOAD = 8'h00;
	localparam logic [7:0] TMR_COUNT  = 8'h08;
	localparam logic [7:0] TMR_CTRL   = 8'h10;

endpackage

`default_nettype wire

// ==== src/text_mem.sv ====
`default_nettype none

module text_mem #(
	parameter int TEXT_WORDS = 2048
) (
	input  logic             clk,
	input  logic             reset_i,
	input  soc_pkg::io_req_t req_i,
	output soc_pkg::io_rsp_t rsp_o
);
	import soc_pkg::*;

	localparam int AW = $clog2(TEXT_WORDS);

	io_data_t       mem [TEXT_WORDS];
	io_data_t       rd_q;
	logic           ack_q;
	logic           access;
	logic [AW-1:0]  idx;

	assign idx    = req_i.adr[AW+1:2]; // 4-byte words
	assign access = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk) begin
		if (reset_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	always_ff @(posedge clk) begin
		if (access && req_i.we) begin
			for (int i = 0; i < 4; i++)
				if (req_i.sel[i])
					mem[idx][i*8 +: 8] <= req_i.dat[i*8 +: 8];
		end
		if (access)
			rd_q <= mem[idx];
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = ack_q ? rd_q : '0; // zero between beats

endmodule

`default_nettype wire

// ==== tests/soc_bus_tb.sv ====
`default_nettype none

module soc_bus_tb;
	import soc_pkg::*;

	localparam int RAM_SLOTS    = 16;
	localparam int RAM_WRITES   = 40;
	localparam int TMR_LOAD     = 5;
	localparam int IDLE_CYCLES  = 20;
	localparam int MAX_WAIT     = 16;
	localparam int RESET_CYCLES = 6;
	localparam int RAM_CYCLES   = (2 * RAM_SLOTS + RAM_WRITES) * 3; // wait, hold, idle
	localparam int TEXT_CYCLES  = 12 * 7;
	localparam int TIMER_CYCLES = 13 * 3 + TMR_LOAD + 2 + IDLE_CYCLES;
	localparam int UNMAP_CYCLES = 2 * 6;
	localparam int WATCHDOG_CYCLES =
		4 * (RESET_CYCLES + RAM_CYCLES + TEXT_CYCLES + TIMER_CYCLES + UNMAP_CYCLES);

	logic     clk;
	logic     reset_i;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	logic     irq;
	int       seed;
	int       check_errs;
	int       other_errs;
	data_t    ram_ref [RAM_SLOTS];
	data_t    txt_ref [4];

	soc_bus_top soc_bus_top_inst (
		.clk       (clk),
		.reset_i   (reset_i),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.irq_o     (irq)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			check_errs++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			check_errs++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp) begin
			check_errs++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic addr_t ram_addr(input int slot);
		return {RAM_BASE_HI, 16'h0100} + addr_t'(slot * 8);
	endfunction

	function automatic addr_t text_addr(input int slot);
		return {TEXT_BASE_HI, 16'h0040} + addr_t'(slot * 8);
	endfunction

	function automatic addr_t tmr_addr(input logic [7:0] offset);
		return {TIMER_BASE, offset};
	endfunction

	// one request, held until ack or err and through the cycle after the pulse
	task automatic bus_cycle(input logic we, input addr_t adr, input sel_t sel,
			input data_t wdat, output bus_rsp_t rsp, output int cycles);
		@(negedge clk);
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we  = we;
		bus_req.sel = sel;
		bus_req.adr = adr;
		bus_req.dat = wdat;
		cycles = 0;
		rsp = '0;
		while (!rsp.ack && !rsp.err && cycles < MAX_WAIT) begin
			@(posedge clk);
			@(negedge clk);
			cycles++;
			rsp = bus_rsp;
		end
		if (!rsp.ack && !rsp.err) begin
			other_errs++;
			$display("no ack or err from address %h within %0d cycles", adr, cycles);
		end else begin
			@(negedge clk);
			check_flag("ack after pulse", bus_rsp.ack, 1'b0); // stb still held here
			check_flag("err after pulse", bus_rsp.err, 1'b0);
		end
		bus_req = '0;
	endtask

	task automatic bus_write(input addr_t adr, input sel_t sel, input data_t dat,
			output bus_rsp_t rsp, output int cycles);
		bus_cycle(1'b1, adr, sel, dat, rsp, cycles);
	endtask

	task automatic bus_read(input addr_t adr, input sel_t sel,
			output bus_rsp_t rsp, output int cycles);
		bus_cycle(1'b0, adr, sel, '0, rsp, cycles);
	endtask

	task automatic check_response(input bus_rsp_t rsp, input int cycles, input int lat);
		check_flag("ack", rsp.ack, 1'b1);
		check_flag("err", rsp.err, 1'b0);
		check_latency("ack latency", cycles, lat);
	endtask

	task automatic check_quiet();
		check_flag("ack", bus_rsp.ack, 1'b0);
		check_flag("err", bus_rsp.err, 1'b0);
		check_flag("irq_o", irq, 1'b0);
	endtask

	task automatic test_reset();
		reset_i = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_quiet();
		end
		reset_i = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_quiet();
		end
	endtask

	task automatic test_ram();
		bus_rsp_t rsp;
		int       cycles;
		int       slot;
		int       i;
		int       b;
		sel_t     sel;
		data_t    dat;
		for (i = 0; i < RAM_SLOTS; i++) begin
			dat = {$random(seed), $random(seed)};
			bus_write(ram_addr(i), 8'hff, dat, rsp, cycles);
			check_response(rsp, cycles, 1);
			ram_ref[i] = dat;
		end
		for (i = 0; i < RAM_WRITES; i++) begin
			slot = $random(seed) & (RAM_SLOTS - 1);
			sel  = sel_t'($random(seed));
			dat  = {$random(seed), $random(seed)};
			bus_write(ram_addr(slot), sel, dat, rsp, cycles);
			check_response(rsp, cycles, 1);
			for (b = 0; b < 8; b++)
				if (sel[b])
					ram_ref[slot][b*8 +: 8] = dat[b*8 +: 8];
		end
		for (i = 0; i < RAM_SLOTS; i++) begin
			bus_read(ram_addr(i), 8'hff, rsp, cycles);
			check_response(rsp, cycles, 1);
			check_data("ram read data", rsp.dat, ram_ref[i]);
		end
	endtask

	task automatic test_text();
		bus_rsp_t rsp;
		int       cycles;
		int       i;
		data_t    dat;
		for (i = 0; i < 4; i++) begin
			dat = {$random(seed), $random(seed)};
			bus_write(text_addr(i), 8'hff, dat, rsp, cycles);
			check_response(rsp, cycles, 5); // two peripheral beats
			txt_ref[i] = dat;
		end
		for (i = 0; i < 4; i++) begin
			bus_read(text_addr(i), 8'hff, rsp, cycles);
			check_response(rsp, cycles, 5);
			check_data("text read data", rsp.dat, txt_ref[i]);
		end
		dat = {$random(seed), $random(seed)};
		bus_write(text_addr(1), 8'hf0, dat, rsp, cycles);
		check_response(rsp, cycles, 3);
		txt_ref[1][63:32] = dat[63:32];
		bus_read(text_addr(1), 8'hff, rsp, cycles);
		check_response(rsp, cycles, 5);
		check_data("text high-only write", rsp.dat, txt_ref[1]);
		bus_read(text_addr(2), 8'h0f, rsp, cycles);
		check_response(rsp, cycles, 3);
		check_data("text low-only read", rsp.dat, {32'h0, txt_ref[2][31:0]});
		bus_read(text_addr(3), 8'hf0, rsp, cycles);
		check_response(rsp, cycles, 3);
		check_data("text high-only read", rsp.dat, {txt_ref[3][63:32], 32'h0});
	endtask

	task automatic test_timer();
		bus_rsp_t rsp;
		int       cycles;
		int       waited;
		int       i;
		bus_write(tmr_addr(TMR_RELOAD), 8'h0f, 64'(TMR_LOAD), rsp, cycles);
		check_response(rsp, cycles, 1);
		bus_write(tmr_addr(TMR_CTRL), 8'h0f, 64'h1, rsp, cycles);
		check_response(rsp, cycles, 1);
		waited = 0;
		while (!irq && waited < TMR_LOAD + 1) begin // enable edge was 1 cycle back
			@(negedge clk);
			waited++;
		end
		check_flag("irq_o", irq, 1'b1);
		for (i = 0; i < 8; i++) begin
			bus_read(tmr_addr(TMR_COUNT), 8'hff, rsp, cycles);
			check_response(rsp, cycles, 1);
			if (rsp.dat > data_t'(TMR_LOAD)) begin
				check_errs++;
				$display("CHECK FAILED TMR_COUNT: got %h, above reload %h", rsp.dat, TMR_LOAD);
			end
		end
		bus_write(tmr_addr(TMR_CTRL), 8'h0f, 64'h3, rsp, cycles); // clear, stay enabled
		check_response(rsp, cycles, 1);
		check_flag("irq_o", irq, 1'b0);
		bus_write(tmr_addr(TMR_CTRL), 8'h0f, 64'h2, rsp, cycles);
		check_response(rsp, cycles, 1);
		check_flag("irq_o", irq, 1'b0);
		bus_read(tmr_addr(TMR_CTRL), 8'hff, rsp, cycles);
		check_response(rsp, cycles, 1);
		check_data("TMR_CTRL", rsp.dat, 64'h0);
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_flag("irq_o", irq, 1'b0);
		end
	endtask

	task automatic test_unmapped();
		bus_rsp_t rsp;
		int       cycles;
		int       n;
		for (n = 0; n < 2; n++) begin
			if (n == 0)
				bus_read(32'h1234_0000, 8'hff, rsp, cycles);
			else
				bus_write(32'h1234_0008, 8'hff, 64'h5a5a_a5a5_0f0f_f0f0, rsp, cycles);
			check_flag("err", rsp.err, 1'b1);
			check_flag("ack", rsp.ack, 1'b0);
			check_latency("err latency", cycles, 1);
			repeat (3) begin
				@(negedge clk);
				check_quiet(); // single err pulse
			end
		end
	endtask

	initial begin
		seed       = 34015;
		check_errs = 0;
		other_errs = 0;
		reset_i    = 1'b1;
		bus_req    = '0;
		test_reset();
		test_ram();
		test_text();
		test_timer();
		test_unmapped();
		@(negedge clk);
		$display("summary: %0d check errors, %0d other errors", check_errs, other_errs);
		if (check_errs == 0 && other_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/soc_pkg.sv
src/bus_fabric.sv
src/scratch_ram.sv
src/io_bridge.sv
src/text_mem.sv
src/interval_timer.sv
src/soc_bus_top.sv
tests/soc_bus_tb.sv
